/* source/iq_settings.svh */
`ifndef IQ_SETTINGS_SVH
`define IQ_SETTINGS_SVH

// number of issue queue slots
`define IQ_DEPTH 8
// slot index width, log2 of the depth
`define IQ_IDX_W 3

// physical register tag width
`define PREG_W 6

// rob index width, the wrap bit sits above it
`define ROB_IDX_W 5

// program counter and immediate widths
`define PC_W 32
`define IMM_W 32

`endif

/* source/iq_pkg.sv */
`include "iq_settings.svh"

package iq_pkg;

    // physical register tag
    typedef logic [`PREG_W-1:0] preg_t;

    // rob id: wrap bit on top of the rob index
    typedef logic [`ROB_IDX_W:0] robid_t;

    typedef logic [`PC_W-1:0] pc_t;

    typedef logic [`IMM_W-1:0] imm_t;

    // one bit per queue slot
    typedef logic [`IQ_DEPTH-1:0] iq_mask_t;

    // integer alu operations carried by each entry
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLL  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_SLT  = 4'd8,
        ALU_SLTU = 4'd9
    } alu_op_e;

endpackage

/* source/iq_entry.sv */
`timescale 1ns/1ps
`include "iq_settings.svh"

module iq_entry (
    input  logic              clock,
    input  logic              rst_n,
    input  logic              write,
    input  iq_pkg::pc_t       enq_pc,
    input  iq_pkg::alu_op_e   enq_alu_op,
    input  iq_pkg::imm_t      enq_imm,
    input  iq_pkg::preg_t     enq_prs1,
    input  iq_pkg::preg_t     enq_prs2,
    input  iq_pkg::preg_t     enq_prd,
    input  logic              enq_src1_is_reg,
    input  logic              enq_src2_is_reg,
    input  logic              enq_src1_ready,
    input  logic              enq_src2_ready,
    input  iq_pkg::robid_t    enq_robid,
    input  logic              wb0_valid,
    input  logic              wb0_need_to_wb,
    input  iq_pkg::preg_t     wb0_prd,
    input  logic              wb1_valid,
    input  logic              wb1_need_to_wb,
    input  iq_pkg::preg_t     wb1_prd,
    input  logic              flush_valid,
    input  iq_pkg::robid_t    flush_robid,
    input  logic              issuing,
    output logic              valid,
    output logic              ready_to_go,
    output iq_pkg::pc_t       entry_pc,
    output iq_pkg::alu_op_e   entry_alu_op,
    output iq_pkg::imm_t      entry_imm,
    output iq_pkg::preg_t     entry_prs1,
    output iq_pkg::preg_t     entry_prs2,
    output logic              entry_src1_is_reg,
    output logic              entry_src2_is_reg,
    output iq_pkg::preg_t     entry_prd,
    output iq_pkg::robid_t    entry_robid
);

    import iq_pkg::*;

    logic src1_state;
    logic src2_state;
    logic enq_src1_wake;
    logic enq_src2_wake;
    logic src1_wake;
    logic src2_wake;
    logic flush_kill;

    // true when either writeback port broadcasts this tag
    function automatic logic wb_hit(input preg_t tag);
        logic hit0;
        logic hit1;
        hit0 = wb0_valid & wb0_need_to_wb & (wb0_prd == tag);
        hit1 = wb1_valid & wb1_need_to_wb & (wb1_prd == tag);
        return hit0 | hit1;
    endfunction

    // wakeup for the incoming tags and for the held tags
    always_comb begin
        enq_src1_wake = enq_src1_is_reg & wb_hit(enq_prs1);
        enq_src2_wake = enq_src2_is_reg & wb_hit(enq_prs2);
        src1_wake     = entry_src1_is_reg & wb_hit(entry_prs1);
        src2_wake     = entry_src2_is_reg & wb_hit(entry_prs2);
    end

    // younger than the flush point: wrap bits differ xor flush index is smaller
    assign flush_kill = valid & flush_valid &
                        ((flush_robid[`ROB_IDX_W] ^ entry_robid[`ROB_IDX_W]) ^
                         (flush_robid[`ROB_IDX_W-1:0] < entry_robid[`ROB_IDX_W-1:0]));

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            valid <= 1'b0;
        end else if (write) begin
            valid <= 1'b1;
        end else if (issuing || flush_kill) begin
            valid <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (write) begin
            entry_pc          <= enq_pc;
            entry_alu_op      <= enq_alu_op;
            entry_imm         <= enq_imm;
            entry_prs1        <= enq_prs1;
            entry_prs2        <= enq_prs2;
            entry_src1_is_reg <= enq_src1_is_reg;
            entry_src2_is_reg <= enq_src2_is_reg;
            entry_prd         <= enq_prd;
            entry_robid       <= enq_robid;
        end
    end

    // a writeback in the enqueue cycle is not lost
    always_ff @(posedge clock) begin
        if (write) begin
            src1_state <= enq_src1_ready | enq_src1_wake;
            src2_state <= enq_src2_ready | enq_src2_wake;
        end else if (valid) begin
            if (src1_wake) begin
                src1_state <= 1'b1;
            end
            if (src2_wake) begin
                src2_state <= 1'b1;
            end
        end
    end

    // immediate operands need no wakeup
    assign ready_to_go = valid &
                         (src1_state | ~entry_src1_is_reg) &
                         (src2_state | ~entry_src2_is_reg);

endmodule

/* source/iq_age_select.sv */
`timescale 1ns/1ps
`include "iq_settings.svh"

module iq_age_select (
    input  logic             clock,
    input  logic             rst_n,
    input  iq_pkg::iq_mask_t write_oh,
    input  iq_pkg::iq_mask_t entry_valid,
    input  iq_pkg::iq_mask_t entry_ready,
    output iq_pkg::iq_mask_t grant_oh,
    output logic             grant_valid
);

    import iq_pkg::*;

    // older[i][j] set means slot j holds an older instruction than slot i
    iq_mask_t older [`IQ_DEPTH];

    iq_mask_t request;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            for (int i = 0; i < `IQ_DEPTH; i++) begin
                older[i] <= '0;
            end
        end else begin
            for (int i = 0; i < `IQ_DEPTH; i++) begin
                for (int j = 0; j < `IQ_DEPTH; j++) begin
                    if (write_oh[i]) begin
                        // everything already present is older
                        older[i][j] <= entry_valid[j];
                    end else if (write_oh[j]) begin
                        // the new occupant of slot j is younger than everyone
                        older[i][j] <= 1'b0;
                    end
                end
            end
        end
    end

    assign request = entry_valid & entry_ready;

    // grant the requester with no older requester
    always_comb begin
        for (int i = 0; i < `IQ_DEPTH; i++) begin
            grant_oh[i] = request[i] & ~(|(older[i] & request));
        end
    end

    assign grant_valid = |grant_oh;

endmodule

/* source/int_issue_queue.sv */
`timescale 1ns/1ps
`include "iq_settings.svh"

module int_issue_queue (
    input  logic              clock,
    input  logic              rst_n,
    input  logic              enq_valid,
    output logic              enq_ready,
    input  iq_pkg::pc_t       enq_pc,
    input  iq_pkg::alu_op_e   enq_alu_op,
    input  iq_pkg::imm_t      enq_imm,
    input  iq_pkg::preg_t     enq_prs1,
    input  iq_pkg::preg_t     enq_prs2,
    input  iq_pkg::preg_t     enq_prd,
    input  logic              enq_src1_is_reg,
    input  logic              enq_src2_is_reg,
    input  logic              enq_src1_ready,
    input  logic              enq_src2_ready,
    input  iq_pkg::robid_t    enq_robid,
    output logic              issue_valid,
    input  logic              issue_ready,
    output iq_pkg::pc_t       issue_pc,
    output iq_pkg::alu_op_e   issue_alu_op,
    output iq_pkg::imm_t      issue_imm,
    output iq_pkg::preg_t     issue_prs1,
    output iq_pkg::preg_t     issue_prs2,
    output logic              issue_src1_is_reg,
    output logic              issue_src2_is_reg,
    output iq_pkg::preg_t     issue_prd,
    output iq_pkg::robid_t    issue_robid,
    input  logic              wb0_valid,
    input  logic              wb0_need_to_wb,
    input  iq_pkg::preg_t     wb0_prd,
    input  logic              wb1_valid,
    input  logic              wb1_need_to_wb,
    input  iq_pkg::preg_t     wb1_prd,
    input  logic              flush_valid,
    input  iq_pkg::robid_t    flush_robid
);

    import iq_pkg::*;

    iq_mask_t entry_valid;
    iq_mask_t entry_ready;
    iq_mask_t free_slots;
    iq_mask_t free_oh;
    iq_mask_t write_oh;
    iq_mask_t grant_oh;
    iq_mask_t issuing_oh;
    logic     grant_valid;

    logic [`IQ_IDX_W-1:0] grant_idx;

    pc_t      entry_pc          [`IQ_DEPTH];
    alu_op_e  entry_alu_op      [`IQ_DEPTH];
    imm_t     entry_imm         [`IQ_DEPTH];
    preg_t    entry_prs1        [`IQ_DEPTH];
    preg_t    entry_prs2        [`IQ_DEPTH];
    preg_t    entry_prd         [`IQ_DEPTH];
    robid_t   entry_robid       [`IQ_DEPTH];
    iq_mask_t entry_src1_is_reg;
    iq_mask_t entry_src2_is_reg;

    // lowest free slot, isolated by the two's complement trick
    assign free_slots = ~entry_valid;
    assign free_oh    = free_slots & (~free_slots + iq_mask_t'(1));

    assign enq_ready = (|free_slots) & ~flush_valid;
    assign write_oh  = free_oh & {`IQ_DEPTH{enq_valid & enq_ready}};

    // nothing issues while a flush is in flight
    assign issue_valid = grant_valid & ~flush_valid;
    assign issuing_oh  = grant_oh & {`IQ_DEPTH{issue_valid & issue_ready}};

    // grant one-hot to slot index
    always_comb begin
        grant_idx = '0;
        for (int i = 0; i < `IQ_DEPTH; i++) begin
            if (grant_oh[i]) begin
                grant_idx = `IQ_IDX_W'(i);
            end
        end
    end

    assign issue_pc          = entry_pc[grant_idx];
    assign issue_alu_op      = entry_alu_op[grant_idx];
    assign issue_imm         = entry_imm[grant_idx];
    assign issue_prs1        = entry_prs1[grant_idx];
    assign issue_prs2        = entry_prs2[grant_idx];
    assign issue_src1_is_reg = entry_src1_is_reg[grant_idx];
    assign issue_src2_is_reg = entry_src2_is_reg[grant_idx];
    assign issue_prd         = entry_prd[grant_idx];
    assign issue_robid       = entry_robid[grant_idx];

    iq_age_select iq_age_select_i (
        .clock      (clock),
        .rst_n      (rst_n),
        .write_oh   (write_oh),
        .entry_valid(entry_valid),
        .entry_ready(entry_ready),
        .grant_oh   (grant_oh),
        .grant_valid(grant_valid)
    );

    // the payload is broadcast, only the slot with write set captures it
    for (genvar i = 0; i < `IQ_DEPTH; i++) begin : g_entry
        iq_entry iq_entry_i (
            .clock            (clock),
            .rst_n            (rst_n),
            .write            (write_oh[i]),
            .enq_pc           (enq_pc),
            .enq_alu_op       (enq_alu_op),
            .enq_imm          (enq_imm),
            .enq_prs1         (enq_prs1),
            .enq_prs2         (enq_prs2),
            .enq_prd          (enq_prd),
            .enq_src1_is_reg  (enq_src1_is_reg),
            .enq_src2_is_reg  (enq_src2_is_reg),
            .enq_src1_ready   (enq_src1_ready),
            .enq_src2_ready   (enq_src2_ready),
            .enq_robid        (enq_robid),
            .wb0_valid        (wb0_valid),
            .wb0_need_to_wb   (wb0_need_to_wb),
            .wb0_prd          (wb0_prd),
            .wb1_valid        (wb1_valid),
            .wb1_need_to_wb   (wb1_need_to_wb),
            .wb1_prd          (wb1_prd),
            .flush_valid      (flush_valid),
            .flush_robid      (flush_robid),
            .issuing          (issuing_oh[i]),
            .valid            (entry_valid[i]),
            .ready_to_go      (entry_ready[i]),
            .entry_pc         (entry_pc[i]),
            .entry_alu_op     (entry_alu_op[i]),
            .entry_imm        (entry_imm[i]),
            .entry_prs1       (entry_prs1[i]),
            .entry_prs2       (entry_prs2[i]),
            .entry_src1_is_reg(entry_src1_is_reg[i]),
            .entry_src2_is_reg(entry_src2_is_reg[i]),
            .entry_prd        (entry_prd[i]),
            .entry_robid      (entry_robid[i])
        );
    end

endmodule

/* verification/iq_test_table.svh */
`ifndef IQ_TEST_TABLE_SVH
`define IQ_TEST_TABLE_SVH

// enqueue_op(robid, prs1, prs2, prd, op, pc, imm, {s1_is_reg, s1_ready, s2_is_reg, s2_ready})
// expect_issue(robid, prd, op, pc, imm)
task automatic build_table();
    // 1: ready instructions leave in enqueue order
    enqueue_op(6'd1, 6'd1, 6'd2, 6'd33, ALU_ADD, 32'h0000_1000, 32'h0000_0011, 4'b1111);
    enqueue_op(6'd2, 6'd3, 6'd4, 6'd34, ALU_XOR, 32'h0000_1004, 32'hffff_fff0, 4'b1111);
    enqueue_op(6'd3, 6'd5, 6'd0, 6'd35, ALU_SRA, 32'h0000_1008, 32'h0000_0003, 4'b1100);
    expect_issue(6'd1, 6'd33, ALU_ADD, 32'h0000_1000, 32'h0000_0011);
    expect_issue(6'd2, 6'd34, ALU_XOR, 32'h0000_1004, 32'hffff_fff0);
    expect_issue(6'd3, 6'd35, ALU_SRA, 32'h0000_1008, 32'h0000_0003);
    expect_flag(F_ISSUE_VALID, 1'b0);

    // 2: fill every slot with instructions waiting on tag 10
    for (int i = 0; i < `IQ_DEPTH; i++) begin
        enqueue_op(robid_t'(4 + i), 6'd10, 6'd0, preg_t'(40 + i), ALU_OR,
                   pc_t'(32'h2000 + 4 * i), imm_t'(i), 4'b1000);
    end
    expect_flag(F_ENQ_READY, 1'b0);
    expect_flag(F_ISSUE_VALID, 1'b0);
    writeback_op(0, 6'd10, 1'b1);
    expect_issue(6'd4, 6'd40, ALU_OR, 32'h0000_2000, 32'h0000_0000);
    expect_flag(F_ENQ_READY, 1'b1);
    for (int i = 1; i < `IQ_DEPTH; i++) begin
        expect_issue(robid_t'(4 + i), preg_t'(40 + i), ALU_OR,
                     pc_t'(32'h2000 + 4 * i), imm_t'(i));
    end

    // 3: wakeup only with need_to_wb set, on each port
    enqueue_op(6'd12, 6'd20, 6'd0, 6'd50, ALU_SUB, 32'h0000_3000, 32'h0000_0001, 4'b1000);
    writeback_op(0, 6'd20, 1'b0);
    idle_for(2);
    expect_flag(F_ISSUE_VALID, 1'b0);
    writeback_op(0, 6'd20, 1'b1);
    expect_issue(6'd12, 6'd50, ALU_SUB, 32'h0000_3000, 32'h0000_0001);
    enqueue_op(6'd13, 6'd7, 6'd21, 6'd51, ALU_SLT, 32'h0000_3004, 32'h0000_0002, 4'b1110);
    writeback_op(1, 6'd21, 1'b0);
    idle_for(2);
    expect_flag(F_ISSUE_VALID, 1'b0);
    writeback_op(1, 6'd21, 1'b1);
    expect_issue(6'd13, 6'd51, ALU_SLT, 32'h0000_3004, 32'h0000_0002);

    // 4: a younger ready entry passes an older blocked one
    enqueue_op(6'd14, 6'd30, 6'd0, 6'd52, ALU_AND, 32'h0000_4000, 32'h0000_00ff, 4'b1000);
    enqueue_op(6'd15, 6'd8, 6'd9, 6'd53, ALU_SLL, 32'h0000_4004, 32'h0000_0004, 4'b1111);
    expect_issue(6'd15, 6'd53, ALU_SLL, 32'h0000_4004, 32'h0000_0004);
    // rob 16 takes a higher slot than the younger rob 17
    enqueue_op(6'd16, 6'd31, 6'd0, 6'd54, ALU_SRL, 32'h0000_4008, 32'h0000_0005, 4'b1000);
    writeback_op(0, 6'd30, 1'b1);
    expect_issue(6'd14, 6'd52, ALU_AND, 32'h0000_4000, 32'h0000_00ff);
    enqueue_op(6'd17, 6'd32, 6'd0, 6'd55, ALU_SLTU, 32'h0000_400c, 32'h0000_0006, 4'b1000);
    writeback_op(1, 6'd32, 1'b1);
    writeback_op(0, 6'd31, 1'b1);
    expect_issue(6'd16, 6'd54, ALU_SRL, 32'h0000_4008, 32'h0000_0005);
    expect_issue(6'd17, 6'd55, ALU_SLTU, 32'h0000_400c, 32'h0000_0006);

    // 5: flush younger entries, also across the wrap bit
    for (int i = 0; i < 4; i++) begin
        enqueue_op(robid_t'(18 + i), 6'd40, 6'd0, preg_t'(56 + i), ALU_ADD,
                   pc_t'(32'h5000 + 4 * i), imm_t'(i), 4'b1000);
    end
    flush_op(6'd19);
    writeback_op(0, 6'd40, 1'b1);
    expect_issue(6'd18, 6'd56, ALU_ADD, 32'h0000_5000, 32'h0000_0000);
    expect_issue(6'd19, 6'd57, ALU_ADD, 32'h0000_5004, 32'h0000_0001);
    expect_flag(F_ISSUE_VALID, 1'b0);
    enqueue_op(6'd30, 6'd41, 6'd0, 6'd60, ALU_SUB, 32'h0000_6000, 32'h0000_0010, 4'b1000);
    enqueue_op(6'd31, 6'd41, 6'd0, 6'd61, ALU_SUB, 32'h0000_6004, 32'h0000_0011, 4'b1000);
    enqueue_op(6'd32, 6'd41, 6'd0, 6'd62, ALU_SUB, 32'h0000_6008, 32'h0000_0012, 4'b1000);
    enqueue_op(6'd33, 6'd41, 6'd0, 6'd63, ALU_SUB, 32'h0000_600c, 32'h0000_0013, 4'b1000);
    flush_op(6'd31);
    enqueue_op(6'd32, 6'd2, 6'd3, 6'd20, ALU_OR, 32'h0000_6010, 32'h0000_0020, 4'b1111);
    writeback_op(1, 6'd41, 1'b1);
    expect_issue(6'd30, 6'd60, ALU_SUB, 32'h0000_6000, 32'h0000_0010);
    expect_issue(6'd31, 6'd61, ALU_SUB, 32'h0000_6004, 32'h0000_0011);
    expect_issue(6'd32, 6'd20, ALU_OR, 32'h0000_6010, 32'h0000_0020);
    expect_flag(F_ISSUE_VALID, 1'b0);

    // 6: random back-pressure keeps the order
    random_ready(1'b1);
    for (int i = 0; i < 6; i++) begin
        enqueue_op(robid_t'(34 + i), 6'd1, 6'd2, preg_t'(i), ALU_XOR,
                   pc_t'(32'h7000 + 4 * i), imm_t'(100 + i), 4'b1111);
    end
    for (int i = 0; i < 6; i++) begin
        expect_issue(robid_t'(34 + i), preg_t'(i), ALU_XOR,
                     pc_t'(32'h7000 + 4 * i), imm_t'(100 + i));
    end
    random_ready(1'b0);
    expect_flag(F_ISSUE_VALID, 1'b0);
endtask

`endif

/* verification/int_issue_queue_tb.sv */
`timescale 1ns/1ps
`include "iq_settings.svh"

module int_issue_queue_tb;

    import iq_pkg::*;

    localparam int K_ENQ = 0;
    localparam int K_WB0 = 1;
    localparam int K_WB1 = 2;
    localparam int K_FLUSH = 3;
    localparam int K_ISSUE = 4;
    localparam int K_IDLE = 5;
    localparam int K_FLAG = 6;
    localparam int K_RAND = 7;

    localparam int F_ENQ_READY = 0;
    localparam int F_ISSUE_VALID = 1;

    logic clock;
    logic rst_n;
    logic enq_valid;
    logic enq_ready;
    pc_t enq_pc;
    alu_op_e enq_alu_op;
    imm_t enq_imm;
    preg_t enq_prs1;
    preg_t enq_prs2;
    preg_t enq_prd;
    logic enq_src1_is_reg;
    logic enq_src2_is_reg;
    logic enq_src1_ready;
    logic enq_src2_ready;
    robid_t enq_robid;
    logic issue_valid;
    logic issue_ready;
    pc_t issue_pc;
    alu_op_e issue_alu_op;
    imm_t issue_imm;
    preg_t issue_prs1;
    preg_t issue_prs2;
    logic issue_src1_is_reg;
    logic issue_src2_is_reg;
    preg_t issue_prd;
    robid_t issue_robid;
    logic wb0_valid;
    logic wb0_need_to_wb;
    preg_t wb0_prd;
    logic wb1_valid;
    logic wb1_need_to_wb;
    preg_t wb1_prd;
    logic flush_valid;
    robid_t flush_robid;

    // one row per entry in these queues
    int kind_q[$];
    robid_t robid_q[$];
    preg_t prs1_q[$];
    preg_t prs2_q[$];
    preg_t prd_q[$];
    alu_op_e op_q[$];
    pc_t pc_q[$];
    imm_t imm_q[$];
    logic [3:0] flags_q[$];

    logic [31:0] lfsr;
    logic random_mode;
    int cycles;
    int cycle_limit;

    int_issue_queue int_issue_queue_i (.*);

    always #50 clock = ~clock;

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles > cycle_limit) begin
            $display("timeout: no progress after %0d cycles", cycles);
            $display("*** FAILED ***");
            $fatal(1);
        end
    end

    task automatic push_row(input int kind, input robid_t robid, input preg_t prs1,
                            input preg_t prs2, input preg_t prd, input alu_op_e op,
                            input pc_t pc, input imm_t imm, input logic [3:0] flags);
        kind_q.push_back(kind);
        robid_q.push_back(robid);
        prs1_q.push_back(prs1);
        prs2_q.push_back(prs2);
        prd_q.push_back(prd);
        op_q.push_back(op);
        pc_q.push_back(pc);
        imm_q.push_back(imm);
        flags_q.push_back(flags);
    endtask

    task automatic enqueue_op(input robid_t robid, input preg_t prs1, input preg_t prs2,
                              input preg_t prd, input alu_op_e op, input pc_t pc,
                              input imm_t imm, input logic [3:0] flags);
        push_row(K_ENQ, robid, prs1, prs2, prd, op, pc, imm, flags);
    endtask

    task automatic writeback_op(input int port, input preg_t tag, input logic need);
        push_row(port == 0 ? K_WB0 : K_WB1, '0, tag, '0, '0, ALU_ADD, '0, '0, {3'b0, need});
    endtask

    task automatic flush_op(input robid_t robid);
        push_row(K_FLUSH, robid, '0, '0, '0, ALU_ADD, '0, '0, 4'b0);
    endtask

    task automatic expect_issue(input robid_t robid, input preg_t prd, input alu_op_e op,
                                input pc_t pc, input imm_t imm);
        push_row(K_ISSUE, robid, '0, '0, prd, op, pc, imm, 4'b0);
    endtask

    task automatic idle_for(input int n);
        push_row(K_IDLE, '0, '0, '0, '0, ALU_ADD, '0, imm_t'(n), 4'b0);
    endtask

    task automatic expect_flag(input int which, input logic value);
        push_row(K_FLAG, '0, '0, '0, '0, ALU_ADD, '0, imm_t'(which), {3'b0, value});
    endtask

    task automatic random_ready(input logic on);
        push_row(K_RAND, '0, '0, '0, '0, ALU_ADD, '0, '0, {3'b0, on});
    endtask

    `include "iq_test_table.svh"

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // latest enqueue row before row r that carries the same rob id
    function automatic int find_enqueue(input int r);
        int found;
        found = -1;
        for (int i = 0; i < r; i++) begin
            if (kind_q[i] == K_ENQ && robid_q[i] == robid_q[r]) begin
                found = i;
            end
        end
        return found;
    endfunction

    // one lfsr step per drawn bit
    task automatic draw_ready(output logic r);
        if (random_mode) begin
            r = lfsr[0];
            lfsr = lfsr_step(lfsr);
        end else begin
            r = 1'b1;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Error at %0t ns: %s is %b, expected %b", $time, name, got, exp);
            $display("*** FAILED ***");
            $fatal(1);
        end
    endtask

    // is_reg holds {src1, src2}
    task automatic check_uop(input robid_t got_robid, input preg_t got_prd,
                             input alu_op_e got_op, input pc_t got_pc, input imm_t got_imm,
                             input preg_t got_prs1, input preg_t got_prs2,
                             input logic [1:0] got_is_reg,
                             input robid_t exp_robid, input preg_t exp_prd,
                             input alu_op_e exp_op, input pc_t exp_pc, input imm_t exp_imm,
                             input preg_t exp_prs1, input preg_t exp_prs2,
                             input logic [1:0] exp_is_reg);
        if (got_robid !== exp_robid || got_prd !== exp_prd || got_op !== exp_op ||
            got_pc !== exp_pc || got_imm !== exp_imm || got_prs1 !== exp_prs1 ||
            got_prs2 !== exp_prs2 || got_is_reg !== exp_is_reg) begin
            $display("Error at %0t ns: issued rob %0d prd %0d op %s pc %h imm %h",
                     $time, got_robid, got_prd, got_op.name(), got_pc, got_imm);
            $display("Error at %0t ns: issued prs1 %0d prs2 %0d is_reg %b",
                     $time, got_prs1, got_prs2, got_is_reg);
            $display("Error at %0t ns: expected rob %0d prd %0d op %s pc %h imm %h",
                     $time, exp_robid, exp_prd, exp_op.name(), exp_pc, exp_imm);
            $display("Error at %0t ns: expected prs1 %0d prs2 %0d is_reg %b",
                     $time, exp_prs1, exp_prs2, exp_is_reg);
            $display("*** FAILED ***");
            $fatal(1);
        end
    endtask

    task automatic drive_idle();
        enq_valid = 1'b0;
        wb0_valid = 1'b0;
        wb0_need_to_wb = 1'b0;
        wb1_valid = 1'b0;
        wb1_need_to_wb = 1'b0;
        flush_valid = 1'b0;
        issue_ready = 1'b0;
    endtask

    // hold issue_ready until a handshake is seen in the low phase
    task automatic wait_issue(input int r);
        logic done;
        int e;
        done = 1'b0;
        e = find_enqueue(r);
        if (e < 0) begin
            $display("table row %0d expects an issue that no earlier row enqueues", r);
            $display("*** FAILED ***");
            $fatal(1);
        end
        draw_ready(issue_ready);
        #10;
        while (!done) begin
            if (issue_valid && issue_ready) begin
                check_uop(issue_robid, issue_prd, issue_alu_op, issue_pc, issue_imm,
                          issue_prs1, issue_prs2, {issue_src1_is_reg, issue_src2_is_reg},
                          robid_q[r], prd_q[r], op_q[r], pc_q[r], imm_q[r],
                          prs1_q[e], prs2_q[e], {flags_q[e][3], flags_q[e][1]});
                done = 1'b1;
                @(posedge clock);
            end else begin
                @(posedge clock);
                @(negedge clock);
                draw_ready(issue_ready);
                #10;
            end
        end
    endtask

    task automatic apply_row(input int r);
        @(negedge clock);
        drive_idle();
        case (kind_q[r])
            K_ENQ: begin
                enq_valid = 1'b1;
                enq_robid = robid_q[r];
                enq_prs1 = prs1_q[r];
                enq_prs2 = prs2_q[r];
                enq_prd = prd_q[r];
                enq_alu_op = op_q[r];
                enq_pc = pc_q[r];
                enq_imm = imm_q[r];
                {enq_src1_is_reg, enq_src1_ready, enq_src2_is_reg, enq_src2_ready} = flags_q[r];
                #10;
                check_flag("enq_ready", enq_ready, 1'b1);
                @(posedge clock);
            end
            K_WB0: begin
                wb0_valid = 1'b1;
                wb0_need_to_wb = flags_q[r][0];
                wb0_prd = prs1_q[r];
                @(posedge clock);
            end
            K_WB1: begin
                wb1_valid = 1'b1;
                wb1_need_to_wb = flags_q[r][0];
                wb1_prd = prs1_q[r];
                @(posedge clock);
            end
            K_FLUSH: begin
                flush_valid = 1'b1;
                flush_robid = robid_q[r];
                @(posedge clock);
            end
            K_ISSUE: begin
                wait_issue(r);
            end
            K_IDLE: begin
                repeat (int'(imm_q[r])) @(posedge clock);
            end
            K_FLAG: begin
                #10;
                if (imm_q[r] == F_ENQ_READY) begin
                    check_flag("enq_ready", enq_ready, flags_q[r][0]);
                end else begin
                    check_flag("issue_valid", issue_valid, flags_q[r][0]);
                end
                @(posedge clock);
            end
            default: begin
                random_mode = flags_q[r][0];
                @(posedge clock);
            end
        endcase
    endtask

    initial begin
        clock = 1'b0;
        rst_n = 1'b0;
        cycles = 0;
        cycle_limit = 1000;
        lfsr = 32'hc074_171d;
        random_mode = 1'b0;
        enq_pc = '0;
        enq_alu_op = ALU_ADD;
        enq_imm = '0;
        enq_prs1 = '0;
        enq_prs2 = '0;
        enq_prd = '0;
        enq_src1_is_reg = 1'b0;
        enq_src2_is_reg = 1'b0;
        enq_src1_ready = 1'b0;
        enq_src2_ready = 1'b0;
        enq_robid = '0;
        wb0_prd = '0;
        wb1_prd = '0;
        flush_robid = '0;
        drive_idle();

        build_table();
        cycle_limit = 20 * kind_q.size() + 200;

        repeat (10) @(negedge clock);
        rst_n = 1'b1;
        #10;
        check_flag("enq_ready", enq_ready, 1'b1);
        check_flag("issue_valid", issue_valid, 1'b0);

        for (int r = 0; r < kind_q.size(); r++) begin
            apply_row(r);
        end

        @(negedge clock);
        drive_idle();
        $display("*** PASSED ***");
        $finish;
    end

endmodule

/* int_issue_queue.f */
+incdir+source
+incdir+verification
source/iq_pkg.sv
source/iq_entry.sv
source/iq_age_select.sv
source/int_issue_queue.sv
verification/int_issue_queue_tb.sv

/* Bender.yml */
package:
  name: int_issue_queue

sources:
  - include_dirs:
      - source
    files:
      - source/iq_pkg.sv
      - source/iq_entry.sv
      - source/iq_age_select.sv
      - source/int_issue_queue.sv
  - target: test
    include_dirs:
      - source
      - verification
    files:
      - verification/int_issue_queue_tb.sv
